//--- sources.f
+incdir+.
ctrlPipePkg.sv
cop0File.sv
instrDecode.sv
stageDelay.sv
memStage.sv
ctrlPipe.sv
ctrlPipeTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module ctrlPipeTb -o ctrlPipeSim

# The simulator exits non-zero on a failure, the log decides the result
./obj_dir/ctrlPipeSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TEST OK" sim.log; then
	exit 1
fi
exit 0

//--- ctrlPipeTb.sv
`timescale 1ns/100ps
`include "ctrlPipe_defs.svh"

module ctrlPipeTb import ctrlPipePkg::*; ();

	localparam int clkPeriod = 8;
	localparam int numInstr = 2000;
	localparam int resetCycles = 8;

	// One pipeline slot of the reference model
	typedef struct packed {
		logic                  valid;
		memOp_t                memOp;
		logic                  isLoad;
		logic                  isStore;
		logic                  sys;
		logic                  brk;
		logic                  mvTo;
		logic                  mvFrom;
		logic [`COP_NUM_W-1:0] copNum;
		logic [15:0]           offset;
		logic [`INSTR_W-1:0]   data;
	} slot_t;

	logic                  phi1;
	logic                  rstN;
	logic                  inValid;
	logic                  inReady;
	instrWord_t            inInstr;
	logic [`INSTR_W-1:0]   inData;
	logic                  bKill;
	logic                  outValid;
	logic                  outReady;
	memOp_t                outMemOp;
	logic                  outIsLoad;
	logic                  outIsStore;
	logic                  outSyscall;
	logic                  outBreak;
	logic                  outMvToCop0;
	logic                  outMvFromCop0;
	logic [`COP_NUM_W-1:0] outCopNum;
	logic [15:0]           outOffset;
	logic [`INSTR_W-1:0]   outData;

	slot_t                 exeSlot;
	slot_t                 memSlot;
	slot_t                 outSlot;
	logic [`INSTR_W-1:0]   copModel [`COP_REGS];
	int                    outCount;
	int                    errCount;
	integer                seed;

	ctrlPipe u_dut (.*);

	initial begin
		phi1 = 1'b0;
		forever #(clkPeriod / 2) phi1 = ~phi1;
	end

	task automatic failRun();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic checkMemOp(input string name, input memOp_t got, input memOp_t exp);
		if (got !== exp) begin
			errCount++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			failRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errCount++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			failRun();
		end
	endtask

	task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errCount++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			failRun();
		end
	endtask

	// Decode table worked from raw bit positions of the instruction word
	function automatic slot_t decodeWord(input logic [31:0] w, input logic [31:0] data);
		slot_t      s;
		logic [5:0] op;
		s = '0;
		op = w[31:26];
		s.valid = 1'b1;
		s.copNum = w[14:11];
		s.offset = w[15:0];
		s.data = data;
		case (op)
			6'h20, 6'h28: s.memOp = memByte;
			6'h21, 6'h29: s.memOp = memHalf;
			6'h23, 6'h2B: s.memOp = memWord;
			6'h24:        s.memOp = memByteU;
			6'h25:        s.memOp = memHalfU;
			default:      s.memOp = memNone;
		endcase
		s.isLoad = (op >= 6'h20) && (op <= 6'h25) && (op != 6'h22);
		s.isStore = (op == 6'h28) || (op == 6'h29) || (op == 6'h2B);
		s.sys = (op == 6'h00) && (w[5:0] == 6'h0C);
		s.brk = (op == 6'h00) && (w[5:0] == 6'h0D);
		s.mvTo = (op == 6'h10) && (w[25:21] == 5'd4);
		s.mvFrom = (op == 6'h10) && (w[25:21] == 5'd0);
		return s;
	endfunction

	// Cancelled instruction keeps valid bit and payload only
	function automatic slot_t cancelFlags(input slot_t s);
		slot_t c;
		c = s;
		c.memOp = memNone;
		c.isLoad = 1'b0;
		c.isStore = 1'b0;
		c.sys = 1'b0;
		c.brk = 1'b0;
		c.mvTo = 1'b0;
		c.mvFrom = 1'b0;
		return c;
	endfunction

	task automatic compareOutput();
		checkMemOp("outMemOp", outMemOp, outSlot.memOp);
		checkFlag("outIsLoad", outIsLoad, outSlot.isLoad);
		checkFlag("outIsStore", outIsStore, outSlot.isStore);
		checkFlag("outSyscall", outSyscall, outSlot.sys);
		checkFlag("outBreak", outBreak, outSlot.brk);
		checkFlag("outMvToCop0", outMvToCop0, outSlot.mvTo);
		checkFlag("outMvFromCop0", outMvFromCop0, outSlot.mvFrom);
		checkWord("outCopNum", 32'(outCopNum), 32'(outSlot.copNum));
		checkWord("outOffset", 32'(outOffset), 32'(outSlot.offset));
		checkWord("outData", outData, outSlot.data);
	endtask

	// Runs mid-cycle, then predicts the state after the coming rising edge
	task automatic stepModel();
		logic  modelStall;
		logic  cancel;
		slot_t leaving;
		modelStall = outSlot.valid & ~outReady;
		checkFlag("outValid", outValid, outSlot.valid);
		checkFlag("inReady", inReady, ~modelStall);
		if (outSlot.valid) begin
			compareOutput();
		end
		if (outSlot.valid && outReady) begin
			outCount++;
		end
		if (!modelStall) begin
			cancel = bKill | (memSlot.valid & (memSlot.sys | memSlot.brk));
			leaving = memSlot;
			if (memSlot.mvFrom) begin
				leaving.data = copModel[memSlot.copNum];
			end
			if (memSlot.valid && memSlot.mvTo) begin
				copModel[memSlot.copNum] = memSlot.data;
			end
			outSlot = leaving;
			memSlot = cancel ? cancelFlags(exeSlot) : exeSlot;
			exeSlot = inValid ? decodeWord(inInstr, inData) : '0;
		end
	endtask

	// Opcode mix leans on loads, stores, traps and cop0 moves
	task automatic driveRandom();
		logic [31:0] w;
		int          pick;
		w = $random(seed);
		pick = ($random(seed) & 32'h7fffffff) % 16;
		case (pick)
			0:  w[31:26] = 6'h20;
			1:  w[31:26] = 6'h21;
			2:  w[31:26] = 6'h23;
			3:  w[31:26] = 6'h24;
			4:  w[31:26] = 6'h25;
			5:  w[31:26] = 6'h28;
			6:  w[31:26] = 6'h29;
			7:  w[31:26] = 6'h2B;
			8:  w = {6'h00, w[25:6], 6'h0C};
			9:  w = {6'h00, w[25:6], 6'h0D};
			10, 11: w = {6'h10, 5'd4, w[20:0]};
			12, 13: w = {6'h10, 5'd0, w[20:0]};
			default: ;
		endcase
		inInstr = w;
		inData = $random(seed);
		inValid = ($random(seed) & 3) != 0;
		bKill = ($random(seed) & 7) == 0;
		outReady = ($random(seed) & 3) != 0;
	endtask

	initial begin
		seed = 32'hb5ba314b;
		rstN = 1'b0;
		inValid = 1'b0;
		inInstr = '0;
		inData = '0;
		bKill = 1'b0;
		outReady = 1'b0;
		exeSlot = '0;
		memSlot = '0;
		outSlot = '0;
		outCount = 0;
		errCount = 0;
		for (int idx = 0; idx < `COP_REGS; idx++) begin
			copModel[idx] = '0;
		end
		repeat (resetCycles) @(posedge phi1);
		#1;
		rstN = 1'b1;
		forever begin
			@(posedge phi1);
			#1;
			driveRandom();
		end
	end

	always @(negedge phi1) begin
		if (rstN) begin
			stepModel();
		end
	end

	initial begin
		wait (outCount >= numInstr);
		if (errCount == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			failRun();
		end
	end

	// Allows eight cycles per instruction
	initial begin
		#(numInstr * 8 * clkPeriod);
		$display("Watchdog expired before all instructions left the pipeline");
		failRun();
	end

endmodule

//--- ctrlPipe.sv
`timescale 1ns/100ps
`include "ctrlPipe_defs.svh"

module ctrlPipe import ctrlPipePkg::*; (
	input  logic                  phi1,
	input  logic                  rstN,
	input  logic                  inValid,
	output logic                  inReady,
	input  instrWord_t            inInstr,
	input  logic [`INSTR_W-1:0]   inData,
	input  logic                  bKill,
	output logic                  outValid,
	input  logic                  outReady,
	output memOp_t                outMemOp,
	output logic                  outIsLoad,
	output logic                  outIsStore,
	output logic                  outSyscall,
	output logic                  outBreak,
	output logic                  outMvToCop0,
	output logic                  outMvFromCop0,
	output logic [`COP_NUM_W-1:0] outCopNum,
	output logic [15:0]           outOffset,
	output logic [`INSTR_W-1:0]   outData
);

	// Execute stage
	logic                  eValid;
	memOp_t                eMemOp;
	logic                  eIsLoad;
	logic                  eIsStore;
	logic                  eSyscall;
	logic                  eBreak;
	logic                  eMvToCop0;
	logic                  eMvFromCop0;
	logic [`COP_NUM_W-1:0] eCopNum;
	logic [15:0]           eOffset;
	logic [`INSTR_W-1:0]   eData;

	// Memory stage
	logic                  mValid;
	memOp_t                mMemOp;
	logic                  mIsLoad;
	logic                  mIsStore;
	logic                  mSyscall;
	logic                  mBreak;
	logic                  mMvToCop0;
	logic                  mMvFromCop0;
	logic [`COP_NUM_W-1:0] mCopNum;
	logic [15:0]           mOffset;
	logic [`INSTR_W-1:0]   mData;

	logic                  stall;
	logic                  except;

	// Cop0 port
	logic                  we;
	logic [`COP_NUM_W-1:0] wNum;
	logic [`INSTR_W-1:0]   wData;
	logic [`COP_NUM_W-1:0] rNum;
	logic [`INSTR_W-1:0]   rData;

	// Port names match the local wires one for one
	instrDecode uDecode (.*);
	stageDelay  uDelay  (.*);
	memStage    uMem    (.*);
	cop0File    uCop0   (.*);

endmodule

//--- memStage.sv
`timescale 1ns/100ps
`include "ctrlPipe_defs.svh"

module memStage import ctrlPipePkg::*; (
	input  logic                  phi1,
	input  logic                  rstN,
	input  logic                  mValid,
	input  memOp_t                mMemOp,
	input  logic                  mIsLoad,
	input  logic                  mIsStore,
	input  logic                  mSyscall,
	input  logic                  mBreak,
	input  logic                  mMvToCop0,
	input  logic                  mMvFromCop0,
	input  logic [`COP_NUM_W-1:0] mCopNum,
	input  logic [15:0]           mOffset,
	input  logic [`INSTR_W-1:0]   mData,
	input  logic                  outReady,
	output logic                  stall,
	output logic                  outValid,
	output memOp_t                outMemOp,
	output logic                  outIsLoad,
	output logic                  outIsStore,
	output logic                  outSyscall,
	output logic                  outBreak,
	output logic                  outMvToCop0,
	output logic                  outMvFromCop0,
	output logic [`COP_NUM_W-1:0] outCopNum,
	output logic [15:0]           outOffset,
	output logic [`INSTR_W-1:0]   outData,
	output logic                  we,
	output logic [`COP_NUM_W-1:0] wNum,
	output logic [`INSTR_W-1:0]   wData,
	output logic [`COP_NUM_W-1:0] rNum,
	input  logic [`INSTR_W-1:0]   rData
);

	// Back-pressure on a full output register freezes the whole pipe
	assign stall = outValid & ~outReady;

	// Cop0 access happens as the instruction moves into the output register
	assign we = ~stall & mValid & mMvToCop0;
	assign wNum = mCopNum;
	assign wData = mData;
	assign rNum = mCopNum;

	always_ff @(posedge phi1 or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
			outMemOp <= memNone;
			outIsLoad <= 1'b0;
			outIsStore <= 1'b0;
			outSyscall <= 1'b0;
			outBreak <= 1'b0;
			outMvToCop0 <= 1'b0;
			outMvFromCop0 <= 1'b0;
		end else if (!stall) begin
			outValid <= mValid;
			outMemOp <= mMemOp;
			outIsLoad <= mIsLoad;
			outIsStore <= mIsStore;
			outSyscall <= mSyscall;
			outBreak <= mBreak;
			outMvToCop0 <= mMvToCop0;
			outMvFromCop0 <= mMvFromCop0;
		end
	end

	always_ff @(posedge phi1) begin
		if (!stall) begin
			outCopNum <= mCopNum;
			outOffset <= mOffset;
			// move-from returns the cop0 register instead of the operand
			outData <= mMvFromCop0 ? rData : mData;
		end
	end

	outputHolds: assert property (@(posedge phi1) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable({outMemOp, outIsLoad, outIsStore,
			outSyscall, outBreak, outMvToCop0, outMvFromCop0, outCopNum, outOffset, outData}))
		else $error("output changed while held by back-pressure");

endmodule

//--- stageDelay.sv
`timescale 1ns/100ps
`include "ctrlPipe_defs.svh"

module stageDelay import ctrlPipePkg::*; (
	input  logic                  phi1,
	input  logic                  rstN,
	input  logic                  stall,
	input  logic                  bKill,
	input  logic                  eValid,
	input  memOp_t                eMemOp,
	input  logic                  eIsLoad,
	input  logic                  eIsStore,
	input  logic                  eSyscall,
	input  logic                  eBreak,
	input  logic                  eMvToCop0,
	input  logic                  eMvFromCop0,
	input  logic [`COP_NUM_W-1:0] eCopNum,
	input  logic [15:0]           eOffset,
	input  logic [`INSTR_W-1:0]   eData,
	output logic                  mValid,
	output memOp_t                mMemOp,
	output logic                  mIsLoad,
	output logic                  mIsStore,
	output logic                  mSyscall,
	output logic                  mBreak,
	output logic                  mMvToCop0,
	output logic                  mMvFromCop0,
	output logic [`COP_NUM_W-1:0] mCopNum,
	output logic [15:0]           mOffset,
	output logic [`INSTR_W-1:0]   mData,
	output logic                  except
);

	logic keep;

	// A live trap in the memory slot takes the exception path
	assign except = mValid & (mSyscall | mBreak);

	// Branch kill or exception strips the flags of the entering instruction
	assign keep = ~(bKill | except);

	always_ff @(posedge phi1 or negedge rstN) begin
		if (!rstN) begin
			mValid <= 1'b0;
			mMemOp <= memNone;
			mIsLoad <= 1'b0;
			mIsStore <= 1'b0;
			mSyscall <= 1'b0;
			mBreak <= 1'b0;
			mMvToCop0 <= 1'b0;
			mMvFromCop0 <= 1'b0;
		end else if (!stall) begin
			mValid <= eValid;
			mMemOp <= keep ? eMemOp : memNone;
			mIsLoad <= eIsLoad & keep;
			mIsStore <= eIsStore & keep;
			mSyscall <= eSyscall & keep;
			mBreak <= eBreak & keep;
			mMvToCop0 <= eMvToCop0 & keep;
			mMvFromCop0 <= eMvFromCop0 & keep;
		end
	end

	// Valid bit and payload pass even when cancelled
	always_ff @(posedge phi1) begin
		if (!stall) begin
			mCopNum <= eCopNum;
			mOffset <= eOffset;
			mData <= eData;
		end
	end

	loadStoreExclusive: assert property (@(posedge phi1) disable iff (!rstN)
		mValid |-> !(mIsLoad && mIsStore))
		else $error("memory slot is both a load and a store");

	cancelClears: assert property (@(posedge phi1) disable iff (!rstN)
		!stall && (bKill || except) |=>
			!(mIsLoad || mIsStore || mSyscall || mBreak || mMvToCop0 || mMvFromCop0)
			&& (mMemOp == memNone))
		else $error("cancelled instruction entered memory stage with flags set");

endmodule

//--- instrDecode.sv
`timescale 1ns/100ps
`include "ctrlPipe_defs.svh"

module instrDecode import ctrlPipePkg::*; (
	input  logic                  phi1,
	input  logic                  rstN,
	input  logic                  inValid,
	output logic                  inReady,
	input  instrWord_t            inInstr,
	input  logic [`INSTR_W-1:0]   inData,
	input  logic                  stall,
	output logic                  eValid,
	output memOp_t                eMemOp,
	output logic                  eIsLoad,
	output logic                  eIsStore,
	output logic                  eSyscall,
	output logic                  eBreak,
	output logic                  eMvToCop0,
	output logic                  eMvFromCop0,
	output logic [`COP_NUM_W-1:0] eCopNum,
	output logic [15:0]           eOffset,
	output logic [`INSTR_W-1:0]   eData
);

	logic   accept;
	memOp_t dMemOp;
	logic   dIsLoad;
	logic   dIsStore;
	logic   dSyscall;
	logic   dBreak;
	logic   dMvTo;
	logic   dMvFrom;

	assign inReady = ~stall;
	assign accept = inValid & inReady;

	// Loads and stores come from the immediate view
	always_comb begin
		case (inInstr.i.op)
			opLb, opSb: dMemOp = memByte;
			opLh, opSh: dMemOp = memHalf;
			opLw, opSw: dMemOp = memWord;
			opLbu:      dMemOp = memByteU;
			opLhu:      dMemOp = memHalfU;
			default:    dMemOp = memNone;
		endcase
		dIsLoad = inInstr.i.op inside {opLb, opLh, opLw, opLbu, opLhu};
		dIsStore = inInstr.i.op inside {opSb, opSh, opSw};
	end

	// Traps and cop0 moves come from the register view
	assign dSyscall = (inInstr.r.op == opSpecial) && (inInstr.r.funct == functSyscall);
	assign dBreak = (inInstr.r.op == opSpecial) && (inInstr.r.funct == functBreak);
	assign dMvTo = (inInstr.r.op == opCop0) && (inInstr.r.rs == rsMtc0);
	assign dMvFrom = (inInstr.r.op == opCop0) && (inInstr.r.rs == rsMfc0);

	// Execute-stage control, a bubble when nothing is accepted
	always_ff @(posedge phi1 or negedge rstN) begin
		if (!rstN) begin
			eValid <= 1'b0;
			eMemOp <= memNone;
			eIsLoad <= 1'b0;
			eIsStore <= 1'b0;
			eSyscall <= 1'b0;
			eBreak <= 1'b0;
			eMvToCop0 <= 1'b0;
			eMvFromCop0 <= 1'b0;
		end else if (!stall) begin
			eValid <= accept;
			eMemOp <= accept ? dMemOp : memNone;
			eIsLoad <= accept & dIsLoad;
			eIsStore <= accept & dIsStore;
			eSyscall <= accept & dSyscall;
			eBreak <= accept & dBreak;
			eMvToCop0 <= accept & dMvTo;
			eMvFromCop0 <= accept & dMvFrom;
		end
	end

	// Payload, cop0 register number taken from rd
	always_ff @(posedge phi1) begin
		if (accept) begin
			eCopNum <= inInstr.r.rd[`COP_NUM_W-1:0];
			eOffset <= inInstr.i.imm;
			eData <= inData;
		end
	end

	mvDirExclusive: assert property (@(posedge phi1) disable iff (!rstN)
		!(eMvToCop0 && eMvFromCop0))
		else $error("execute slot holds both move-to and move-from cop0");

endmodule

//--- cop0File.sv
`timescale 1ns/100ps
`include "ctrlPipe_defs.svh"

module cop0File (
	input  logic                  phi1,
	input  logic                  rstN,
	input  logic                  we,
	input  logic [`COP_NUM_W-1:0] wNum,
	input  logic [`INSTR_W-1:0]   wData,
	input  logic [`COP_NUM_W-1:0] rNum,
	output logic [`INSTR_W-1:0]   rData
);

	logic [`INSTR_W-1:0] regs [`COP_REGS];

	// All cop0 registers come up as zero
	always_ff @(posedge phi1 or negedge rstN) begin
		if (!rstN) begin
			for (int idx = 0; idx < `COP_REGS; idx++) begin
				regs[idx] <= '0;
			end
		end else if (we) begin
			regs[wNum] <= wData;
		end
	end

	// Read is combinational, old value seen on a same-edge write
	assign rData = regs[rNum];

endmodule

//--- ctrlPipePkg.sv
package ctrlPipePkg;

	// One instruction word, read as register fields or as immediate fields
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
	} instrWord_t;

	// Memory operation carried down to the load/store unit
	typedef enum logic [2:0] {
		memNone  = 3'd0,
		memByte  = 3'd1,
		memHalf  = 3'd2,
		memWord  = 3'd3,
		memByteU = 3'd4,
		memHalfU = 3'd5
	} memOp_t;

	// Major opcodes
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opCop0    = 6'h10;
	localparam logic [5:0] opLb      = 6'h20;
	localparam logic [5:0] opLh      = 6'h21;
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opLbu     = 6'h24;
	localparam logic [5:0] opLhu     = 6'h25;
	localparam logic [5:0] opSb      = 6'h28;
	localparam logic [5:0] opSh      = 6'h29;
	localparam logic [5:0] opSw      = 6'h2B;

	// Function codes under opSpecial
	localparam logic [5:0] functSyscall = 6'h0C;
	localparam logic [5:0] functBreak   = 6'h0D;

	// rs field selects the cop0 move direction
	localparam logic [4:0] rsMfc0 = 5'd0;
	localparam logic [4:0] rsMtc0 = 5'd4;

endpackage

//--- ctrlPipe_defs.svh
`ifndef CTRLPIPE_DEFS_SVH
`define CTRLPIPE_DEFS_SVH

// Instruction and operand width
`define INSTR_W 32

// Coprocessor-0 register count and register number width
`define COP_REGS 16
`define COP_NUM_W 4

`endif
